// ==== axi_types_pkg.sv ====
package axi_types_pkg;

  ////////////////////////////////
  // Field widths
  ////////////////////////////////

  // Transaction ID
  typedef logic [3:0]  id_t;

  // Byte address
  typedef logic [31:0] addr_t;

  // One data beat
  typedef logic [31:0] data_t;

  // Byte lane strobes
  typedef logic [3:0]  strb_t;

  // Burst length minus one
  typedef logic [7:0]  len_t;

  // Response code
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  ////////////////////////////////
  // Channel payloads
  ////////////////////////////////

  // Shared by AW and AR
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_req_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_beat_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_resp_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_beat_t;

endpackage

// ==== fw_map_pkg.sv ====
package fw_map_pkg;

  ////////////////////////////////
  // Denied address windows
  ////////////////////////////////

  localparam int WINDOW_COUNT = 4;

  // 4 KB aligned bases that master 3 may not reach
  localparam axi_types_pkg::addr_t WINDOW_BASE [WINDOW_COUNT] = '{
    32'h0000_0000,
    32'h0000_4000,
    32'h0000_6000,
    32'h0000_8000
  };

  // Offset bits inside one window
  localparam axi_types_pkg::addr_t WINDOW_MASK = 32'h0000_0FFF;

  ////////////////////////////////
  // Address check
  ////////////////////////////////

  // True when the address lies in any denied window
  function automatic logic addr_denied(input axi_types_pkg::addr_t addr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < WINDOW_COUNT; i++)
    begin
      if ((addr & ~WINDOW_MASK) == WINDOW_BASE[i])
      begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

endpackage

// ==== fw_write_path.sv ====
module fw_write_path (
  input  logic                   axi_master_3_slave_router_clk,
  input  logic                   axi_master_3_slave_router_rstn,

  input  axi_types_pkg::aw_req_t s_aw,
  input  logic                   s_aw_valid,
  output logic                   s_aw_ready,
  input  axi_types_pkg::w_beat_t s_w,
  input  logic                   s_w_valid,
  output logic                   s_w_ready,
  output axi_types_pkg::b_resp_t s_b,
  output logic                   s_b_valid,
  input  logic                   s_b_ready,

  output axi_types_pkg::aw_req_t m_aw,
  output logic                   m_aw_valid,
  input  logic                   m_aw_ready,
  output axi_types_pkg::w_beat_t m_w,
  output logic                   m_w_valid,
  input  logic                   m_w_ready,
  input  axi_types_pkg::b_resp_t m_b,
  input  logic                   m_b_valid,
  output logic                   m_b_ready
);

  typedef enum logic [2:0] {
    IDLE,
    PASS_DATA,
    PASS_RESP,
    BLOCK_DATA,
    BLOCK_RESP
  } wr_state_t;

  wr_state_t           state;
  wr_state_t           state_nxt;
  logic                aw_denied;
  axi_types_pkg::id_t  blk_id;

  assign aw_denied = fw_map_pkg::addr_denied(s_aw.addr);

  // Request and data payloads go downstream untouched
  assign m_aw = s_aw;
  assign m_w  = s_w;

  ////////////////////////////////
  // Channel routing
  ////////////////////////////////

  always_comb
  begin
    state_nxt  = state;
    s_aw_ready = 1'b0;
    m_aw_valid = 1'b0;
    s_w_ready  = 1'b0;
    m_w_valid  = 1'b0;
    s_b_valid  = 1'b0;
    m_b_ready  = 1'b0;
    s_b        = m_b;
    case (state)
      IDLE:
      begin
        m_aw_valid = s_aw_valid && !aw_denied;
        s_aw_ready = s_aw_valid && (aw_denied || m_aw_ready);
        if (s_aw_valid && aw_denied)
          state_nxt = BLOCK_DATA;
        else if (s_aw_valid && m_aw_ready)
          state_nxt = PASS_DATA;
      end
      PASS_DATA:
      begin
        m_w_valid = s_w_valid;
        s_w_ready = m_w_ready;
        if (s_w_valid && m_w_ready && s_w.last)
          state_nxt = PASS_RESP;
      end
      PASS_RESP:
      begin
        s_b_valid = m_b_valid;
        m_b_ready = s_b_ready;
        if (m_b_valid && s_b_ready)
          state_nxt = IDLE;
      end
      BLOCK_DATA:
      begin
        // Absorb every beat, ends on WLAST
        s_w_ready = 1'b1;
        if (s_w_valid && s_w.last)
          state_nxt = BLOCK_RESP;
      end
      BLOCK_RESP:
      begin
        s_b_valid = 1'b1;
        s_b.id    = blk_id;
        s_b.resp  = axi_types_pkg::RESP_DECERR;
        if (s_b_ready)
          state_nxt = IDLE;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge axi_master_3_slave_router_clk or negedge axi_master_3_slave_router_rstn)
  begin
    if (!axi_master_3_slave_router_rstn)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  // ID of the denied write, returned with its DECERR
  always_ff @(posedge axi_master_3_slave_router_clk)
  begin
    if (state == IDLE && s_aw_valid && aw_denied)
      blk_id <= s_aw.id;
  end

endmodule

// ==== fw_read_path.sv ====
module fw_read_path (
  input  logic                   axi_master_3_slave_router_clk,
  input  logic                   axi_master_3_slave_router_rstn,

  input  axi_types_pkg::aw_req_t s_ar,
  input  logic                   s_ar_valid,
  output logic                   s_ar_ready,
  output axi_types_pkg::r_beat_t s_r,
  output logic                   s_r_valid,
  input  logic                   s_r_ready,

  output axi_types_pkg::aw_req_t m_ar,
  output logic                   m_ar_valid,
  input  logic                   m_ar_ready,
  input  axi_types_pkg::r_beat_t m_r,
  input  logic                   m_r_valid,
  output logic                   m_r_ready
);

  typedef enum logic [1:0] {
    IDLE,
    PASS_DATA,
    BLOCK_DATA
  } rd_state_t;

  rd_state_t            state;
  rd_state_t            state_nxt;
  logic                 ar_denied;
  logic                 blk_last;
  axi_types_pkg::id_t   blk_id;
  axi_types_pkg::len_t  blk_len;
  axi_types_pkg::len_t  beat_cnt;

  assign ar_denied = fw_map_pkg::addr_denied(s_ar.addr);
  assign m_ar      = s_ar;

  // Final local beat once the count reaches ARLEN
  assign blk_last  = (beat_cnt == blk_len);

  ////////////////////////////////
  // Channel routing
  ////////////////////////////////

  always_comb
  begin
    state_nxt  = state;
    s_ar_ready = 1'b0;
    m_ar_valid = 1'b0;
    s_r_valid  = 1'b0;
    m_r_ready  = 1'b0;
    s_r        = m_r;
    case (state)
      IDLE:
      begin
        m_ar_valid = s_ar_valid && !ar_denied;
        s_ar_ready = s_ar_valid && (ar_denied || m_ar_ready);
        if (s_ar_valid && ar_denied)
          state_nxt = BLOCK_DATA;
        else if (s_ar_valid && m_ar_ready)
          state_nxt = PASS_DATA;
      end
      PASS_DATA:
      begin
        s_r_valid = m_r_valid;
        m_r_ready = s_r_ready;
        if (m_r_valid && s_r_ready && m_r.last)
          state_nxt = IDLE;
      end
      BLOCK_DATA:
      begin
        // Zero data with DECERR on every beat
        s_r_valid = 1'b1;
        s_r.id    = blk_id;
        s_r.data  = '0;
        s_r.resp  = axi_types_pkg::RESP_DECERR;
        s_r.last  = blk_last;
        if (s_r_ready && blk_last)
          state_nxt = IDLE;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  ////////////////////////////////
  // State and beat counter
  ////////////////////////////////

  always_ff @(posedge axi_master_3_slave_router_clk or negedge axi_master_3_slave_router_rstn)
  begin
    if (!axi_master_3_slave_router_rstn)
    begin
      state    <= IDLE;
      beat_cnt <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (state == IDLE)
        beat_cnt <= '0;
      else if (state == BLOCK_DATA && s_r_ready && !blk_last)
        beat_cnt <= beat_cnt + 8'd1;
    end
  end

  // Request fields kept for the local burst
  always_ff @(posedge axi_master_3_slave_router_clk)
  begin
    if (state == IDLE && s_ar_valid && ar_denied)
    begin
      blk_id  <= s_ar.id;
      blk_len <= s_ar.len;
    end
  end

endmodule

// ==== axi_m3_firewall.sv ====
module axi_m3_firewall (
  input  logic                   axi_master_3_slave_router_clk,
  input  logic                   axi_master_3_slave_router_rstn,

  // Toward master 3
  input  axi_types_pkg::aw_req_t s_aw,
  input  logic                   s_aw_valid,
  output logic                   s_aw_ready,
  input  axi_types_pkg::w_beat_t s_w,
  input  logic                   s_w_valid,
  output logic                   s_w_ready,
  output axi_types_pkg::b_resp_t s_b,
  output logic                   s_b_valid,
  input  logic                   s_b_ready,
  input  axi_types_pkg::aw_req_t s_ar,
  input  logic                   s_ar_valid,
  output logic                   s_ar_ready,
  output axi_types_pkg::r_beat_t s_r,
  output logic                   s_r_valid,
  input  logic                   s_r_ready,

  // Toward the interconnect
  output axi_types_pkg::aw_req_t m_aw,
  output logic                   m_aw_valid,
  input  logic                   m_aw_ready,
  output axi_types_pkg::w_beat_t m_w,
  output logic                   m_w_valid,
  input  logic                   m_w_ready,
  input  axi_types_pkg::b_resp_t m_b,
  input  logic                   m_b_valid,
  output logic                   m_b_ready,
  output axi_types_pkg::aw_req_t m_ar,
  output logic                   m_ar_valid,
  input  logic                   m_ar_ready,
  input  axi_types_pkg::r_beat_t m_r,
  input  logic                   m_r_valid,
  output logic                   m_r_ready
);

  fw_write_path u_write_path (
    .axi_master_3_slave_router_clk  (axi_master_3_slave_router_clk),
    .axi_master_3_slave_router_rstn (axi_master_3_slave_router_rstn),
    .s_aw (s_aw), .s_aw_valid (s_aw_valid), .s_aw_ready (s_aw_ready),
    .s_w  (s_w),  .s_w_valid  (s_w_valid),  .s_w_ready  (s_w_ready),
    .s_b  (s_b),  .s_b_valid  (s_b_valid),  .s_b_ready  (s_b_ready),
    .m_aw (m_aw), .m_aw_valid (m_aw_valid), .m_aw_ready (m_aw_ready),
    .m_w  (m_w),  .m_w_valid  (m_w_valid),  .m_w_ready  (m_w_ready),
    .m_b  (m_b),  .m_b_valid  (m_b_valid),  .m_b_ready  (m_b_ready)
  );

  fw_read_path u_read_path (
    .axi_master_3_slave_router_clk  (axi_master_3_slave_router_clk),
    .axi_master_3_slave_router_rstn (axi_master_3_slave_router_rstn),
    .s_ar (s_ar), .s_ar_valid (s_ar_valid), .s_ar_ready (s_ar_ready),
    .s_r  (s_r),  .s_r_valid  (s_r_valid),  .s_r_ready  (s_r_ready),
    .m_ar (m_ar), .m_ar_valid (m_ar_valid), .m_ar_ready (m_ar_ready),
    .m_r  (m_r),  .m_r_valid  (m_r_valid),  .m_r_ready  (m_r_ready)
  );

endmodule

// ==== tb_fw_assert.sv ====
module fw_assert (
  input logic                   axi_master_3_slave_router_clk,
  input logic                   axi_master_3_slave_router_rstn,
  input axi_types_pkg::aw_req_t m_aw,
  input logic                   m_aw_valid,
  input axi_types_pkg::aw_req_t m_ar,
  input logic                   m_ar_valid,
  input logic                   m_w_valid,
  input axi_types_pkg::b_resp_t s_b,
  input logic                   s_b_valid,
  input logic                   s_b_ready,
  input axi_types_pkg::r_beat_t s_r,
  input logic                   s_r_valid,
  input logic                   s_r_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  // The four denied 4 KB pages
  function automatic logic in_window(input axi_types_pkg::addr_t addr);
    return addr[31:12] inside {20'h00000, 20'h00004, 20'h00006, 20'h00008};
  endfunction

  // Denied addresses never reach the interconnect
  aw_not_denied: assert property (@(posedge axi_master_3_slave_router_clk)
    disable iff (!axi_master_3_slave_router_rstn)
    m_aw_valid |-> !in_window(m_aw.addr))
    else $error("m_aw_valid with a denied address");

  ar_not_denied: assert property (@(posedge axi_master_3_slave_router_clk)
    disable iff (!axi_master_3_slave_router_rstn)
    m_ar_valid |-> !in_window(m_ar.addr))
    else $error("m_ar_valid with a denied address");

  // Responses hold under back-pressure
  b_hold: assert property (@(posedge axi_master_3_slave_router_clk)
    disable iff (!axi_master_3_slave_router_rstn)
    s_b_valid && !s_b_ready |=> s_b_valid && $stable(s_b))
    else $error("s_b changed before its transfer");

  r_hold: assert property (@(posedge axi_master_3_slave_router_clk)
    disable iff (!axi_master_3_slave_router_rstn)
    s_r_valid && !s_r_ready |=> s_r_valid && $stable(s_r))
    else $error("s_r changed before its transfer");

  reset_quiet: assert property (@(posedge axi_master_3_slave_router_clk)
    !axi_master_3_slave_router_rstn |->
      !(s_b_valid || s_r_valid || m_aw_valid || m_ar_valid || m_w_valid))
    else $error("valid high during reset");

endmodule

bind axi_m3_firewall fw_assert u_fw_assert (
  .axi_master_3_slave_router_clk  (axi_master_3_slave_router_clk),
  .axi_master_3_slave_router_rstn (axi_master_3_slave_router_rstn),
  .m_aw (m_aw), .m_aw_valid (m_aw_valid), .m_ar (m_ar), .m_ar_valid (m_ar_valid),
  .m_w_valid (m_w_valid),
  .s_b (s_b), .s_b_valid (s_b_valid), .s_b_ready (s_b_ready),
  .s_r (s_r), .s_r_valid (s_r_valid), .s_r_ready (s_r_ready)
);

// ==== tb_axi_m3_firewall.sv ====
module tb_axi_m3_firewall;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TRANS   = 200;
  localparam int CYCLE_LIMIT = NUM_TRANS * (8 + 12);

  logic clk;
  logic rstn;
  axi_types_pkg::aw_req_t s_aw, s_ar, m_aw, m_ar, cur_wr, cur_rd, slv_aw, slv_ar;
  axi_types_pkg::w_beat_t s_w, m_w, exp_w;
  axi_types_pkg::b_resp_t s_b, m_b, exp_b;
  axi_types_pkg::r_beat_t s_r, m_r, exp_r;
  logic s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_b_valid, s_b_ready;
  logic s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
  logic m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
  logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
  logic aw_fire, w_last_fire, b_fire, ar_fire, r_fire, b_prev_valid, r_active;
  int errors, cycle, wlast_cycle, b_done, rd_done, r_seen, w_seen, r_idx;

  axi_m3_firewall UUT (.axi_master_3_slave_router_clk(clk),
    .axi_master_3_slave_router_rstn(rstn), .*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Data rule shared by the master's writes and the slave model's reads
  function automatic axi_types_pkg::data_t beat_data(axi_types_pkg::addr_t a, int idx);
    return (a ^ 32'hA5A5_0000) + idx * 32'h0101_0101;
  endfunction

  // Denied when the address lies in the 4 KB above any window base
  function automatic logic in_denied_window(axi_types_pkg::addr_t a);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      if (a >= fw_map_pkg::WINDOW_BASE[i] && a - fw_map_pkg::WINDOW_BASE[i] < 32'h1000)
        hit = 1'b1;
    end
    return hit;
  endfunction

  // Expected response for beat idx of a request
  function automatic axi_types_pkg::r_beat_t ref_r(axi_types_pkg::aw_req_t req, int idx);
    axi_types_pkg::r_beat_t b;
    b.id   = req.id;
    b.last = (idx == int'(req.len));
    if (in_denied_window(req.addr))
    begin
      b.data = '0;
      b.resp = axi_types_pkg::RESP_DECERR;
    end
    else
    begin
      b.data = beat_data(req.addr, idx);
      b.resp = axi_types_pkg::RESP_OKAY;
    end
    return b;
  endfunction

  task automatic report_mismatch(string name, logic [63:0] exp_v, logic [63:0] act_v);
    $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    errors++;
  endtask

  function automatic axi_types_pkg::addr_t pick_addr();
    axi_types_pkg::addr_t base;
    base = fw_map_pkg::WINDOW_BASE[$urandom % 4];
    case ($urandom % 4)
      0: return base;
      1: return base + 32'h0FFF;
      2: return base + 32'h1000;
      default: return base - 32'h1;
    endcase
  endfunction

  task automatic write_burst(axi_types_pkg::aw_req_t req);
    @(negedge clk);
    cur_wr = req;
    w_seen = 0;
    s_aw = req;
    s_aw_valid = 1'b1;
    do @(posedge clk); while (!s_aw_ready);
    for (int i = 0; i <= int'(req.len); i++)
    begin
      @(negedge clk);
      s_aw_valid = 1'b0;
      s_w = '{beat_data(req.addr, i), 4'hF, i == int'(req.len)};
      s_w_valid = 1'b1;
      do @(posedge clk); while (!s_w_ready);
    end
    @(negedge clk);
    s_w_valid = 1'b0;
    wait (b_done == 1);
    b_done = 0;
  endtask

  task automatic read_burst(axi_types_pkg::aw_req_t req);
    @(negedge clk);
    cur_rd = req;
    r_seen = 0;
    s_ar = req;
    s_ar_valid = 1'b1;
    do @(posedge clk); while (!s_ar_ready);
    @(negedge clk);
    s_ar_valid = 1'b0;
    wait (rd_done == 1);
    rd_done = 0;
  endtask

  ////////////////////////////////
  // Downstream slave model
  ////////////////////////////////

  initial
  begin
    m_aw_ready = 0;
    m_w_ready = 0;
    m_b_valid = 0;
    m_b = '0;
    m_ar_ready = 0;
    m_r_valid = 0;
    m_r = '0;
    s_b_ready = 0;
    s_r_ready = 0;
    r_active = 0;
    r_idx = 0;
    slv_aw = '0;
    slv_ar = '0;
    forever
    begin
      @(posedge clk);
      aw_fire     = m_aw_valid && m_aw_ready;
      w_last_fire = m_w_valid && m_w_ready && m_w.last;
      b_fire      = m_b_valid && m_b_ready;
      ar_fire     = m_ar_valid && m_ar_ready;
      r_fire      = m_r_valid && m_r_ready;
      if (aw_fire)
        slv_aw = m_aw;
      @(negedge clk);
      if (b_fire)
        m_b_valid = 1'b0;
      if (w_last_fire)
      begin
        m_b_valid = 1'b1;
        m_b = '{slv_aw.id, axi_types_pkg::RESP_OKAY};
      end
      if (r_fire)
      begin
        r_active = !m_r.last;
        r_idx++;
      end
      if (ar_fire)
      begin
        slv_ar = m_ar;
        r_active = 1'b1;
        r_idx = 0;
      end
      m_r_valid = r_active;
      m_r = '{slv_ar.id, beat_data(slv_ar.addr, r_idx), axi_types_pkg::RESP_OKAY,
              r_idx == int'(slv_ar.len)};
      m_aw_ready = ($urandom % 4) != 0;
      m_w_ready  = ($urandom % 4) != 0;
      m_ar_ready = ($urandom % 4) != 0;
      s_b_ready  = ($urandom % 3) != 0;
      s_r_ready  = ($urandom % 3) != 0;
    end
  end

  ////////////////////////////////
  // Compare process
  ////////////////////////////////

  always @(posedge clk)
  begin
    cycle++;
    if (m_aw_valid && m_aw != cur_wr)
      report_mismatch("m_aw", cur_wr, m_aw);
    if (m_aw_valid && in_denied_window(cur_wr.addr))
      report_mismatch("m_aw_valid", 0, m_aw_valid);
    if (m_w_valid && in_denied_window(cur_wr.addr))
      report_mismatch("m_w_valid", 0, m_w_valid);
    if (m_w_valid && m_w_ready)
    begin
      exp_w = '{beat_data(cur_wr.addr, w_seen), 4'hF, w_seen == int'(cur_wr.len)};
      if (m_w != exp_w)
        report_mismatch("m_w", exp_w, m_w);
      w_seen++;
    end
    if (m_ar_valid && m_ar != cur_rd)
      report_mismatch("m_ar", cur_rd, m_ar);
    if (m_ar_valid && in_denied_window(cur_rd.addr))
      report_mismatch("m_ar_valid", 0, m_ar_valid);
    if (s_w_valid && s_w_ready && s_w.last)
      wlast_cycle = cycle;
    if (s_b_valid && !b_prev_valid && in_denied_window(cur_wr.addr)
        && cycle != wlast_cycle + 1)
      report_mismatch("s_b_valid latency", 1, cycle - wlast_cycle);
    b_prev_valid = s_b_valid && !s_b_ready;
    if (s_b_valid && s_b_ready)
    begin
      exp_r = ref_r(cur_wr, 0);
      exp_b = '{exp_r.id, exp_r.resp};
      if (s_b != exp_b)
        report_mismatch("s_b", exp_b, s_b);
      b_done = 1;
    end
    if (s_r_valid && s_r_ready)
    begin
      exp_r = ref_r(cur_rd, r_seen);
      if (s_r != exp_r)
        report_mismatch("s_r", exp_r, s_r);
      r_seen++;
      if (s_r.last || r_seen > int'(cur_rd.len))
        rd_done = 1;
    end
  end

  // Ends a run that stalls
  initial
  begin
    wait (cycle > CYCLE_LIMIT);
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    axi_types_pkg::aw_req_t req;
    void'($urandom(33));
    errors = 0;
    cycle = 0;
    wlast_cycle = 0;
    b_done = 0;
    rd_done = 0;
    r_seen = 0;
    w_seen = 0;
    b_prev_valid = 0;
    cur_wr = '0;
    cur_rd = '0;
    rstn = 1'b0;
    s_aw = '0;
    s_aw_valid = 0;
    s_w = '0;
    s_w_valid = 0;
    s_ar = '0;
    s_ar_valid = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    for (int n = 0; n < NUM_TRANS; n++)
    begin
      req.id   = 4'($urandom);
      req.addr = pick_addr();
      req.len  = 8'($urandom % 8);
      if ($urandom % 2)
        write_burst(req);
      else
        read_burst(req);
    end
    repeat (4) @(posedge clk);
    $display("Run complete: %0d transactions, %0d errors", NUM_TRANS, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== filelist.f ====
axi_types_pkg.sv
fw_map_pkg.sv
fw_write_path.sv
fw_read_path.sv
axi_m3_firewall.sv
tb_fw_assert.sv
tb_axi_m3_firewall.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_m3_firewall
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
